// ==== verilog/spinn_link_defs.svh ====
// link and packet sizes for the 2-of-7 receiver; the eop code and data table assume 7 wires
`ifndef SPINN_LINK_DEFS_SVH
`define SPINN_LINK_DEFS_SVH

// ----------------------------------------
// link word
// ----------------------------------------
`define SL_SYM_BITS     7            // wires on the 2-of-7 link
`define NIBBLE_BITS     4            // data per symbol
`define EOP_CODE        7'b1100000   // eop toggles the two top wires

// ----------------------------------------
// packet framing
// ----------------------------------------
`define PKT_BITS        72   // long packet, header plus payload
`define SHORT_PKT_BITS  40   // short packet, no payload word
`define SHORT_FLITS     10   // nibbles in a short packet
`define LONG_FLITS      18   // nibbles in a long packet

// ----------------------------------------
// clock domain crossing
// ----------------------------------------
`define SYNC_STAGES     2    // flops on each link wire before decode

`endif

// ==== verilog/spinn_link_pkg.sv ====
// types shared by the receiver stages; widths come from the defs header
`include "spinn_link_defs.svh"

package spinn_link_pkg;

  // ----------------------------------------
  // link and packet words
  // ----------------------------------------
  typedef logic [`SL_SYM_BITS-1:0] sym_t;     // raw link word or transition
  typedef logic [`NIBBLE_BITS-1:0] nibble_t;  // decoded data of one symbol
  typedef logic [`PKT_BITS-1:0]    pkt_t;     // assembled packet, long size

  // ----------------------------------------
  // symbol classes
  // ----------------------------------------
  // every complete symbol is exactly one of these
  typedef enum logic [1:0] {
    FLIT_DATA = 2'd0,  // one of the 16 data codes
    FLIT_EOP  = 2'd1,  // end of packet
    FLIT_BAD  = 2'd2   // two or more wires but no valid code
  } flit_kind_e;

  // ----------------------------------------
  // assembler states
  // ----------------------------------------
  typedef enum logic [1:0] {
    ASM_IDLE = 2'd0,  // waiting for the first nibble
    ASM_TRAN = 2'd1,  // collecting nibbles
    ASM_WAIT = 2'd2,  // packet done, output still busy
    ASM_FERR = 2'd3   // dropping symbols until eop
  } asm_state_e;

endpackage

// ==== verilog/flit_if.sv ====
// decoded symbol bus; kind and nibble must hold while vld is high and rdy low
`timescale 1ns/1ps

interface flit_if;

  spinn_link_pkg::flit_kind_e kind;    // data, eop or bad
  spinn_link_pkg::nibble_t    nibble;  // only meaningful for data
  logic                       vld;     // symbol on offer
  logic                       rdy;     // assembler can take it

  // receiver side
  modport producer (
    output kind,
    output nibble,
    output vld,
    input  rdy
  );

  // assembler side
  modport assembler (
    input  kind,
    input  nibble,
    input  vld,
    output rdy
  );

endinterface

// ==== verilog/flit_receiver.sv ====
// expects both wires of a symbol to change together; clock must run during reset to fill sync
`timescale 1ns/1ps
`include "spinn_link_defs.svh"

module flit_receiver (
  input  logic                 CLK_IN,
  input  logic                 RESET_IN,
  input  spinn_link_pkg::sym_t sl_data,
  output logic                 sl_ack,
  flit_if.producer             flit
);

  spinn_link_pkg::sym_t       sync_q [`SYNC_STAGES];  // synchroniser chain
  spinn_link_pkg::sym_t       sync_word;  // last sync stage
  spinn_link_pkg::sym_t       ref_q;      // word after the last accepted symbol
  spinn_link_pkg::sym_t       sym_q;      // word of the symbol on offer
  spinn_link_pkg::sym_t       diff;       // wires toggled since ref_q
  spinn_link_pkg::flit_kind_e kind_d;
  spinn_link_pkg::nibble_t    nib_d;
  logic                       strt_q;     // first cycle out of reset
  logic                       new_sym;
  logic                       load;
  logic                       xfer;

  // ----------------------------------------
  // synchroniser
  // ----------------------------------------
  always_ff @(posedge CLK_IN) begin
    sync_q[0] <= sl_data;
    for (int i = 1; i < `SYNC_STAGES; i++) begin
      sync_q[i] <= sync_q[i-1];
    end
  end

  assign sync_word = sync_q[`SYNC_STAGES-1];

  // ----------------------------------------
  // NRZ transition detect
  // ----------------------------------------
  assign diff    = sync_word ^ ref_q;
  assign new_sym = !strt_q && ($countones(diff) > 1);  // single wire is incomplete
  assign load    = new_sym && !flit.vld;  // one symbol on offer at a time
  assign xfer    = flit.vld && flit.rdy;

  // single classifier for data, eop and bad
  always_comb begin
    kind_d = spinn_link_pkg::FLIT_DATA;
    nib_d  = '0;
    case (diff)
      7'b0010001: nib_d = 4'd0;
      7'b0010010: nib_d = 4'd1;
      7'b0010100: nib_d = 4'd2;
      7'b0011000: nib_d = 4'd3;
      7'b0100001: nib_d = 4'd4;
      7'b0100010: nib_d = 4'd5;
      7'b0100100: nib_d = 4'd6;
      7'b0101000: nib_d = 4'd7;
      7'b1000001: nib_d = 4'd8;
      7'b1000010: nib_d = 4'd9;
      7'b1000100: nib_d = 4'd10;
      7'b1001000: nib_d = 4'd11;
      7'b0000011: nib_d = 4'd12;
      7'b0000110: nib_d = 4'd13;
      7'b0001100: nib_d = 4'd14;
      7'b0001001: nib_d = 4'd15;
      `EOP_CODE:  kind_d = spinn_link_pkg::FLIT_EOP;
      default:    kind_d = spinn_link_pkg::FLIT_BAD;  // three or more wires, or no code
    endcase
  end

  // ----------------------------------------
  // control: start, valid, ack
  // ----------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      strt_q   <= 1'b1;
      sl_ack   <= 1'b0;
      flit.vld <= 1'b0;
    end else begin
      strt_q <= 1'b0;
      if (strt_q || xfer) begin
        sl_ack <= ~sl_ack;  // ack on reset exit, like the chip does
      end
      if (xfer) begin
        flit.vld <= 1'b0;  // bubble so the old diff is not seen twice
      end else if (load) begin
        flit.vld <= 1'b1;
      end
    end
  end

  // symbol payload and reference word
  always_ff @(posedge CLK_IN) begin
    if (load) begin
      sym_q       <= sync_word;
      flit.kind   <= kind_d;
      flit.nibble <= nib_d;
    end
    if (strt_q) begin
      ref_q <= sync_word;  // idle link state after reset
    end else if (xfer) begin
      ref_q <= sym_q;
    end
  end

  // symbol held steady while the assembler stalls
  a_flit_hold: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (flit.vld && !flit.rdy) |=>
      (flit.vld && $stable(flit.kind) && $stable(flit.nibble)));

endmodule

// ==== verilog/pkt_assembler.sv ====
// first nibble lands lowest; a short packet leaves zero-extended in the low bits
`timescale 1ns/1ps
`include "spinn_link_defs.svh"

module pkt_assembler (
  input  logic                 CLK_IN,
  input  logic                 RESET_IN,
  flit_if.assembler            flit,
  output spinn_link_pkg::pkt_t pkt_data,
  output logic                 pkt_vld,
  input  logic                 pkt_rdy,
  output logic                 flt_err,
  output logic                 frm_err
);

  localparam int CNT_BITS = $clog2(`LONG_FLITS + 1);

  spinn_link_pkg::asm_state_e state;
  spinn_link_pkg::pkt_t       pkt_buf;  // shift buffer, fills from the top
  logic [CNT_BITS-1:0]        flit_cnt; // data nibbles in this packet
  logic                       long_q;   // payload flag of the header
  logic                       xfer;
  logic                       is_dat;
  logic                       is_eop;
  logic                       is_bad;
  logic                       exp_eop;  // eop now would close a good packet
  logic                       pkt_busy;
  logic                       send_pkt;
  logic                       rx_open;  // idle or transfer, errors reported

  // ----------------------------------------
  // symbol decode
  // ----------------------------------------
  assign xfer   = flit.vld && flit.rdy;
  assign is_dat = xfer && (flit.kind == spinn_link_pkg::FLIT_DATA);
  assign is_eop = xfer && (flit.kind == spinn_link_pkg::FLIT_EOP);
  assign is_bad = xfer && (flit.kind == spinn_link_pkg::FLIT_BAD);

  assign rx_open  = (state == spinn_link_pkg::ASM_IDLE) ||
                    (state == spinn_link_pkg::ASM_TRAN);
  assign exp_eop  = long_q ? (flit_cnt == CNT_BITS'(`LONG_FLITS))
                           : (flit_cnt == CNT_BITS'(`SHORT_FLITS));
  assign pkt_busy = pkt_vld && !pkt_rdy;
  assign send_pkt = ((state == spinn_link_pkg::ASM_TRAN) && is_eop && exp_eop) ||
                    (state == spinn_link_pkg::ASM_WAIT);

  // ----------------------------------------
  // framing FSM
  // ----------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= spinn_link_pkg::ASM_IDLE;
    end else begin
      case (state)
        spinn_link_pkg::ASM_IDLE: begin
          if (is_dat) begin
            state <= spinn_link_pkg::ASM_TRAN;  // header nibble
          end else if (is_bad) begin
            state <= spinn_link_pkg::ASM_FERR;
          end
        end
        spinn_link_pkg::ASM_TRAN: begin
          if (is_bad) begin
            state <= spinn_link_pkg::ASM_FERR;
          end else if (is_eop) begin
            // wrong count just drops, the eop already closed it
            if (exp_eop && pkt_busy) begin
              state <= spinn_link_pkg::ASM_WAIT;
            end else begin
              state <= spinn_link_pkg::ASM_IDLE;
            end
          end
        end
        spinn_link_pkg::ASM_WAIT: begin
          if (!pkt_busy) begin
            state <= spinn_link_pkg::ASM_IDLE;  // held packet went out
          end
        end
        default: begin
          if (is_eop) begin
            state <= spinn_link_pkg::ASM_IDLE;
          end
        end
      endcase
    end
  end

  // ----------------------------------------
  // counter and flit ready
  // ----------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flit_cnt <= '0;
      flit.rdy <= 1'b1;
    end else begin
      if (state == spinn_link_pkg::ASM_IDLE) begin
        flit_cnt <= is_dat ? CNT_BITS'(1) : '0;
      end else if (state != spinn_link_pkg::ASM_TRAN) begin
        flit_cnt <= '0;
      end else if (is_dat && (flit_cnt != '1)) begin
        flit_cnt <= flit_cnt + CNT_BITS'(1);  // saturates on runaway packets
      end
      if ((state == spinn_link_pkg::ASM_TRAN) && is_eop && exp_eop && pkt_busy) begin
        flit.rdy <= 1'b0;  // stall link until output frees
      end else if (!pkt_busy) begin
        flit.rdy <= 1'b1;
      end
    end
  end

  // shift buffer and header flag, payload only
  always_ff @(posedge CLK_IN) begin
    if (is_dat && rx_open) begin
      pkt_buf <= {flit.nibble, pkt_buf[`PKT_BITS-1:`NIBBLE_BITS]};
    end
    if (is_dat && (state == spinn_link_pkg::ASM_IDLE)) begin
      long_q <= flit.nibble[1];
    end
  end

  // ----------------------------------------
  // packet output register
  // ----------------------------------------
  always_ff @(posedge CLK_IN) begin
    if (send_pkt && !pkt_busy) begin
      pkt_data <= long_q ? pkt_buf : (pkt_buf >> (`PKT_BITS - `SHORT_PKT_BITS));
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_vld <= 1'b0;
      flt_err <= 1'b0;
      frm_err <= 1'b0;
    end else begin
      if (!pkt_busy) begin
        pkt_vld <= send_pkt;
      end
      flt_err <= rx_open && is_bad;              // one cycle pulse
      frm_err <= rx_open && is_eop && !exp_eop;  // eop in idle counts too
    end
  end

  // output held under back-pressure
  a_pkt_hold: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (pkt_vld && !pkt_rdy) |=> (pkt_vld && $stable(pkt_data)));

  // receiver gives one class per symbol
  a_err_excl: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    !(flt_err && frm_err));

endmodule

// ==== verilog/spinn_link_rx.sv ====
// 2-of-7 link receiver top; sl_data is asynchronous, everything else is on CLK_IN
`timescale 1ns/1ps

module spinn_link_rx (
  input  logic                 CLK_IN,
  input  logic                 RESET_IN,
  // link side
  input  spinn_link_pkg::sym_t sl_data,
  output logic                 sl_ack,
  // packet side
  output spinn_link_pkg::pkt_t pkt_data,
  output logic                 pkt_vld,
  input  logic                 pkt_rdy,
  // error pulses
  output logic                 flt_err,
  output logic                 frm_err
);

  flit_if flit_i ();  // decoded symbols, receiver to assembler

  flit_receiver rx_i (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .sl_data  (sl_data),
    .sl_ack   (sl_ack),
    .flit     (flit_i.producer)
  );

  pkt_assembler asm_i (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .flit     (flit_i.assembler),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .flt_err  (flt_err),
    .frm_err  (frm_err)
  );

endmodule

// ==== sim/tb_link_tasks.svh ====
// included into the testbench module; tasks expect to start at a falling clock edge
`ifndef TB_LINK_TASKS_SVH
`define TB_LINK_TASKS_SVH

// ----------------------------------------
// checks
// ----------------------------------------
task automatic fail_run(input string why);
  $display("%s", why);
  $display("TEST FAILED");
  $fatal(1, "simulation stopped at the first failure");
endtask

task automatic check_pkt(input string name, input spinn_link_pkg::pkt_t exp,
                         input spinn_link_pkg::pkt_t act);
  if (act !== exp) begin
    fail_run($sformatf("error at time %0t: %s expected %h got %h", $time, name, exp, act));
  end
endtask

task automatic check_err(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    fail_run($sformatf("error at time %0t: %s expected %b got %b", $time, name, exp, act));
  end
endtask

// ----------------------------------------
// link sender
// ----------------------------------------
task automatic wait_ack(input logic old, input string what);
  int cyc;
  cyc = 0;
  while (sl_ack === old && cyc < ACK_LIMIT) begin
    @(negedge CLK_IN);
    cyc++;
  end
  if (sl_ack === old) begin
    fail_run($sformatf("sl_ack did not toggle within %0d cycles after %s", ACK_LIMIT, what));
  end
endtask

task automatic send_sym(input spinn_link_pkg::sym_t code);
  logic old;
  old     = sl_ack;
  sl_data = sl_data ^ code;  // NRZ, both wires flip together
  wait_ack(old, $sformatf("symbol %b", code));
endtask

`endif

// ==== sim/tb_spinn_link_rx.sv ====
// link sender, packet sink and model; sl_data and pkt_rdy change only at falling edges
`timescale 1ns/1ps
`include "spinn_link_defs.svh"

module tb_spinn_link_rx;

  localparam int ACK_LIMIT = 400;  // cycles, well above any sink stall
  localparam int PKT_LIMIT = 400;

  // transition code of nibbles 0 to 15
  localparam spinn_link_pkg::sym_t DATA_CODE [16] = '{
    7'b0010001, 7'b0010010, 7'b0010100, 7'b0011000,
    7'b0100001, 7'b0100010, 7'b0100100, 7'b0101000,
    7'b1000001, 7'b1000010, 7'b1000100, 7'b1001000,
    7'b0000011, 7'b0000110, 7'b0001100, 7'b0001001};

  logic                 CLK_IN = 1'b0;
  logic                 RESET_IN;
  spinn_link_pkg::sym_t sl_data;
  logic                 sl_ack;
  spinn_link_pkg::pkt_t pkt_data;
  logic                 pkt_vld;
  logic                 pkt_rdy = 1'b1;
  logic                 flt_err;
  logic                 frm_err;

  integer seed      = 32'h27e16ad5;   // link stimulus
  integer sink_seed = ~32'h27e16ad5;  // sink stalls, own stream
  logic   stall_on  = 1'b0;
  logic   flt_prev  = 1'b0;
  logic   frm_prev  = 1'b0;
  int     flt_cnt   = 0;  // pulses seen by the sink
  int     frm_cnt   = 0;
  int     flt_base  = 0;  // counts at the last flag check
  int     frm_base  = 0;
  spinn_link_pkg::pkt_t exp_q [$];  // model output, oldest first

  spinn_link_rx dut_i (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .sl_data  (sl_data),
    .sl_ack   (sl_ack),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .flt_err  (flt_err),
    .frm_err  (frm_err)
  );

  `include "tb_link_tasks.svh"

  always #2 CLK_IN = ~CLK_IN;  // 4 ns period

  // ----------------------------------------
  // sink and monitor
  // ----------------------------------------
  // sample at the falling edge, then pick pkt_rdy for the next rising edge
  always @(negedge CLK_IN) begin
    if (RESET_IN === 1'b0) begin
      if (flt_prev) check_err("flt_err", 1'b0, flt_err);  // pulse is one cycle
      if (frm_prev) check_err("frm_err", 1'b0, frm_err);
      if (flt_err === 1'b1) flt_cnt++;
      if (frm_err === 1'b1) frm_cnt++;
      flt_prev = flt_err;
      frm_prev = frm_err;
    end
    pkt_rdy = stall_on ? ($random(sink_seed) % 2 == 0) : 1'b1;
    if (pkt_vld === 1'b1 && pkt_rdy) begin
      if (exp_q.size() == 0) begin
        fail_run("a packet came out where the model expected none");
      end else begin
        check_pkt("pkt_data", exp_q.pop_front(), pkt_data);
      end
    end
  end

  // ----------------------------------------
  // model and sequence helpers
  // ----------------------------------------
  function automatic int full_count(input logic is_long);
    return is_long ? `LONG_FLITS : `SHORT_FLITS;
  endfunction

  // nibble i sits at bits 4i+3:4i, a short packet is zero above bit 39
  task automatic send_frame(input logic is_long, input int n_nib, input int bad_at);
    spinn_link_pkg::nibble_t nib;
    spinn_link_pkg::pkt_t    exp_pkt;
    exp_pkt = '0;
    for (int i = 0; i < n_nib; i++) begin
      if (i == bad_at) begin
        // three wires at once, no valid code
        send_sym(spinn_link_pkg::sym_t'(7'b0000111 << ({$random(seed)} % 5)));
      end
      nib = spinn_link_pkg::nibble_t'($random(seed));
      if (i == 0) nib[1] = is_long;  // header payload flag
      exp_pkt[4*i +: 4] = nib;
      send_sym(DATA_CODE[nib]);
    end
    if (n_nib == full_count(is_long) && bad_at < 0) exp_q.push_back(exp_pkt);
    send_sym(`EOP_CODE);
  endtask

  task automatic drain_pkts();
    int cyc;
    cyc = 0;
    while (exp_q.size() != 0 && cyc < PKT_LIMIT) begin
      @(posedge CLK_IN);
      cyc++;
    end
    if (exp_q.size() != 0) begin
      fail_run($sformatf("%0d expected packets never came out", exp_q.size()));
    end
    @(negedge CLK_IN);
  endtask

  task automatic check_flags(input logic exp_flt, input logic exp_frm);
    check_err("flt_err", exp_flt, flt_cnt != flt_base);
    check_err("frm_err", exp_frm, frm_cnt != frm_base);
    flt_base = flt_cnt;
    frm_base = frm_cnt;
  endtask

  task automatic set_backpressure(input logic on);
    @(posedge CLK_IN);
    stall_on = on;  // away from the sink's falling edge
    @(negedge CLK_IN);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    logic is_long;
    int   n;
    RESET_IN = 1'b1;
    sl_data  = '0;
    repeat (2) @(posedge CLK_IN);
    @(negedge CLK_IN);
    check_err("sl_ack", 1'b0, sl_ack);
    RESET_IN = 1'b0;
    wait_ack(1'b0, "reset exit");
    repeat (8) @(negedge CLK_IN);
    check_err("sl_ack", 1'b1, sl_ack);  // no second toggle while idle
    check_err("pkt_vld", 1'b0, pkt_vld);
    check_flags(1'b0, 1'b0);

    repeat (6) send_frame(1'b0, `SHORT_FLITS, -1);
    repeat (6) send_frame(1'b1, `LONG_FLITS, -1);
    drain_pkts();
    check_flags(1'b0, 1'b0);

    // sink stalls at random, sender held off by ack
    set_backpressure(1'b1);
    for (int i = 0; i < 16; i++) begin
      is_long = ($random(seed) % 2 == 0);
      send_frame(is_long, full_count(is_long), -1);
    end
    drain_pkts();
    set_backpressure(1'b0);
    check_flags(1'b0, 1'b0);

    // bad symbol mid packet, then a clean one
    for (int i = 0; i < 4; i++) begin
      is_long = ($random(seed) % 2 == 0);
      send_frame(is_long, full_count(is_long), 1 + ({$random(seed)} % 9));
      send_frame(!is_long, full_count(!is_long), -1);
      drain_pkts();
      check_flags(1'b1, 1'b0);
    end

    // eop at a wrong count
    for (int i = 0; i < 4; i++) begin
      is_long = ($random(seed) % 2 == 0);
      n = 1 + ({$random(seed)} % 17);
      if (n == full_count(is_long)) n++;
      send_frame(is_long, n, -1);
      send_frame(is_long, full_count(is_long), -1);
      drain_pkts();
      check_flags(1'b0, 1'b1);
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+verilog
+incdir+sim
verilog/spinn_link_pkg.sv
verilog/flit_if.sv
verilog/flit_receiver.sv
verilog/pkt_assembler.sv
verilog/spinn_link_rx.sv
sim/tb_spinn_link_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the testbench with Verilator; the exit status is the test result
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_spinn_link_rx -f project.f -Mdir obj_dir
./obj_dir/Vtb_spinn_link_rx
